// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_shared_wram
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/wram_ref_model.svh
/*
 * Reference model of the shared WRAM: window decode, grant, SDRAM forwarding
 * and read return timing. Included inside the testbench module.
 */
`ifndef WRAM_REF_MODEL_SVH
`define WRAM_REF_MODEL_SVH

function automatic logic cpu_in_window(cpu_addr_t a);
    return (a >= 22'h006000) && (a < 22'h008000);
endfunction

function automatic logic rv_in_window(rv_addr_t a);
    return (a >= 23'h706000) && (a < 23'h708000);
endfunction

// Predicts one cycle from the inputs that were just applied
task automatic model_step();
    cpu_req_t req;
    logic     v;
    logic     c_hit;
    logic     r_hit;
    logic     r_we;
    logic     g_cpu;
    logic     g_rv;
    rv_data_t half;
    int       cidx;
    int       ridx;
    if (i_rom_loading) begin
        v      = i_loader_req_valid;
        req    = i_loader_req;
        req.we = 1'b1;
    end else begin
        v   = i_cpu_req_valid;
        req = i_cpu_req;
    end
    c_hit = v && cpu_in_window(req.addr);
    r_we  = |i_rv_wstrb;
    half  = i_rv_word ? i_rv_wdata[31:16] : i_rv_wdata[15:0];
    r_hit = i_rv_req && rv_in_window(i_rv_addr);
    g_rv  = r_hit && (!c_hit || i_wram_load_ongoing);
    g_cpu = c_hit && !g_rv;
    cidx  = int'(req.addr) - 'h6000;
    ridx  = int'(i_rv_addr) - 'h706000;

    exp_cpu_fwd        = v && (req.we || !g_cpu);
    exp_cpu_fwd_req    = req;
    exp_rv_fwd         = i_rv_req && (r_we || !g_rv);
    exp_rv_fwd_req.we    = r_we;
    exp_rv_fwd_req.addr  = i_rv_addr;
    exp_rv_fwd_req.wdata = half;
    exp_rv_fwd_req.ds    = i_rv_ds;

    // RAM side, at most one access per cycle
    if (g_cpu && req.we) begin
        mirror[cidx] = req.wdata;
    end else if (g_cpu) begin
        cpu_ret[cyc + 2] = mirror[cidx];
        cpu_busy = cyc + 2;
    end
    if (g_rv && r_we) begin
        mirror[ridx] = half[7:0];
    end else if (g_rv) begin
        rv_ret[cyc + 2] = {8'h00, mirror[ridx]};
        rv_busy = cyc + 2;
    end

    // SDRAM reads answered 3 cycles later, seen 1 cycle after that
    if (exp_cpu_fwd && !req.we) begin
        cpu_resp[cyc + 3] = cpu_sdram[req.addr[7:0]];
        cpu_ret[cyc + 4]  = cpu_sdram[req.addr[7:0]];
        cpu_busy = cyc + 4;
    end
    if (exp_rv_fwd && !r_we) begin
        rv_resp[cyc + 3] = rv_sdram[i_rv_addr[7:0]];
        rv_ret[cyc + 4]  = rv_sdram[i_rv_addr[7:0]];
        rv_busy = cyc + 4;
    end
endtask

`endif

// File: dv/tb_shared_wram.sv
/*
 * Testbench for the shared WRAM top level. Random traffic from both masters
 * and the loader, an SDRAM responder, and a scoreboard fed by the model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_shared_wram
    import wram_pkg::*;
();

    localparam int TOTAL_CYCLES = 1200;
    localparam int LIMIT        = 2 * TOTAL_CYCLES + 100;

    logic        i_clk = 1'b0;
    logic        i_resetn;
    logic        i_cpu_req_valid;
    cpu_req_t    i_cpu_req;
    logic        i_rom_loading;
    logic        i_loader_req_valid;
    cpu_req_t    i_loader_req;
    logic        i_rv_req;
    rv_addr_t    i_rv_addr;
    logic        i_rv_word;
    logic [31:0] i_rv_wdata;
    logic [3:0]  i_rv_wstrb;
    logic [1:0]  i_rv_ds;
    logic        i_wram_load_ongoing;
    logic        o_cpu_ext_valid;
    cpu_req_t    o_cpu_ext_req;
    logic        o_rv_ext_valid;
    rv_req_t     o_rv_ext_req;
    logic        i_cpu_ext_rvalid;
    byte_t       i_cpu_ext_rdata;
    logic        i_rv_ext_rvalid;
    rv_data_t    i_rv_ext_rdata;
    logic        o_cpu_rvalid;
    byte_t       o_cpu_rdata;
    logic        o_rv_rvalid;
    rv_data_t    o_rv_rdata;

    // Stimulus for the next cycle, applied on the falling edge
    logic        s_resetn;
    logic        s_cpu_v;
    logic        s_loading;
    logic        s_ld_v;
    logic        s_rv_v;
    logic        s_rv_word;
    logic        s_load_ongoing;
    cpu_req_t    s_cpu_req;
    cpu_req_t    s_ld_req;
    rv_addr_t    s_rv_addr;
    logic [31:0] s_rv_wdata;
    logic [3:0]  s_rv_wstrb;
    logic [1:0]  s_rv_ds;

    // Scoreboard state shared with the model
    byte_t    mirror [8192];
    byte_t    cpu_sdram [256];
    rv_data_t rv_sdram [256];
    byte_t    cpu_ret [int];
    rv_data_t rv_ret [int];
    byte_t    cpu_resp [int];
    rv_data_t rv_resp [int];
    int       cyc = 0;
    int       cpu_busy = 0;
    int       rv_busy = 0;
    int       clk_count = 0;
    logic     exp_cpu_fwd;
    logic     exp_rv_fwd;
    cpu_req_t exp_cpu_fwd_req;
    rv_req_t  exp_rv_fwd_req;
    string    test_name;
    int       cur_errs = 0;
    int       total_errs = 0;
    int       tests_run = 0;

    `include "wram_ref_model.svh"

    shared_wram_top dut_i (.*);

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        clk_count++;
        if (clk_count > LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic report_value(string what, logic [63:0] exp, logic [63:0] act);
        $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        cur_errs++;
    endtask

    task automatic check_returns();
        logic ev;
        ev = (cpu_ret.exists(cyc) != 0);
        assert (o_cpu_rvalid === ev)
            else report_value("cpu rvalid", 64'(ev), 64'(o_cpu_rvalid));
        if (ev) begin
            assert (o_cpu_rdata === cpu_ret[cyc])
                else report_value("cpu rdata", 64'(cpu_ret[cyc]), 64'(o_cpu_rdata));
            cpu_ret.delete(cyc);
        end
        ev = (rv_ret.exists(cyc) != 0);
        assert (o_rv_rvalid === ev)
            else report_value("rv rvalid", 64'(ev), 64'(o_rv_rvalid));
        if (ev) begin
            assert (o_rv_rdata === rv_ret[cyc])
                else report_value("rv rdata", 64'(rv_ret[cyc]), 64'(o_rv_rdata));
            rv_ret.delete(cyc);
        end
    endtask

    task automatic check_forwards();
        assert (o_cpu_ext_valid === exp_cpu_fwd)
            else report_value("cpu ext_valid", 64'(exp_cpu_fwd), 64'(o_cpu_ext_valid));
        if (exp_cpu_fwd) begin
            assert (o_cpu_ext_req === exp_cpu_fwd_req)
                else report_value("cpu ext_req", 64'(exp_cpu_fwd_req), 64'(o_cpu_ext_req));
        end
        assert (o_rv_ext_valid === exp_rv_fwd)
            else report_value("rv ext_valid", 64'(exp_rv_fwd), 64'(o_rv_ext_valid));
        if (exp_rv_fwd) begin
            assert (o_rv_ext_req === exp_rv_fwd_req)
                else report_value("rv ext_req", 64'(exp_rv_fwd_req), 64'(o_rv_ext_req));
        end
    endtask

    // One clock cycle: check, answer SDRAM, apply stimulus, predict
    task automatic drive_cycle();
        @(negedge i_clk);
        cyc++;
        check_returns();
        i_cpu_ext_rvalid = (cpu_resp.exists(cyc) != 0);
        i_cpu_ext_rdata  = i_cpu_ext_rvalid ? cpu_resp[cyc] : '0;
        i_rv_ext_rvalid  = (rv_resp.exists(cyc) != 0);
        i_rv_ext_rdata   = i_rv_ext_rvalid ? rv_resp[cyc] : '0;
        cpu_resp.delete(cyc);
        rv_resp.delete(cyc);
        i_resetn = s_resetn;
        i_cpu_req_valid = s_cpu_v;
        i_cpu_req = s_cpu_req;
        i_rom_loading = s_loading;
        i_loader_req_valid = s_ld_v;
        i_loader_req = s_ld_req;
        i_rv_req = s_rv_v;
        i_rv_addr = s_rv_addr;
        i_rv_word = s_rv_word;
        i_rv_wdata = s_rv_wdata;
        i_rv_wstrb = s_rv_wstrb;
        i_rv_ds = s_rv_ds;
        i_wram_load_ongoing = s_load_ongoing;
        if (s_resetn) begin
            model_step();
        end else begin
            exp_cpu_fwd = 1'b0;
            exp_rv_fwd  = 1'b0;
        end
        #1;
        check_forwards();
        s_cpu_v = 1'b0;
        s_ld_v  = 1'b0;
        s_rv_v  = 1'b0;
    endtask

    function automatic logic cpu_can_read();
        return cyc + 1 >= cpu_busy;
    endfunction

    function automatic logic rv_can_read();
        return cyc + 1 >= rv_busy;
    endfunction

    task automatic set_cpu(logic we, cpu_addr_t addr);
        s_cpu_v = 1'b1;
        s_cpu_req.we = we;
        s_cpu_req.addr = addr;
        s_cpu_req.wdata = byte_t'($urandom);
    endtask

    task automatic set_rv(logic we, rv_addr_t addr);
        s_rv_v = 1'b1;
        s_rv_addr = addr;
        s_rv_word = 1'($urandom % 2);
        s_rv_wdata = $urandom;
        s_rv_wstrb = we ? 4'(1 + $urandom % 15) : 4'h0;
        s_rv_ds = 2'($urandom % 4);
    endtask

    task automatic start_test(string name);
        test_name = name;
        cur_errs = 0;
    endtask

    // Drain in-flight returns, then report the test
    task automatic finish_test();
        repeat (6) drive_cycle();
        assert (cpu_ret.size() == 0 && rv_ret.size() == 0) else begin
            $display("ERROR %s: read returns still pending after drain", test_name);
            cur_errs++;
        end
        $display("Test %s done: %0d errors", test_name, cur_errs);
        total_errs += cur_errs;
        tests_run++;
    endtask

    task automatic test_reset();
        start_test("reset_state");
        for (int i = 0; i < 4; i++) begin
            s_resetn = (i >= 1);
            drive_cycle();
            assert (!o_cpu_rvalid && !o_rv_rvalid && !o_cpu_ext_valid && !o_rv_ext_valid)
                else begin
                    $display("ERROR %s: an output was active during or after reset", test_name);
                    cur_errs++;
                end
        end
        finish_test();
    endtask

    task automatic test_cpu_rw();
        start_test("cpu_write_read");
        for (int i = 0; i < 32; i++) begin
            set_cpu(1'b1, 22'h006000 + 22'(i));
            drive_cycle();
        end
        repeat (200) begin
            if ($urandom % 2 == 0 || !cpu_can_read()) begin
                set_cpu(1'b1, 22'h006000 + 22'($urandom % 32));
            end else begin
                set_cpu(1'b0, 22'h006000 + 22'($urandom % 32));
            end
            drive_cycle();
        end
        finish_test();
    endtask

    // RV writes and zero-extended RV reads, CPU reads share the window
    task automatic test_rv_map();
        start_test("rv_mapping");
        repeat (200) begin
            if ($urandom % 2 == 0) begin
                set_rv(1'b1, 23'h706000 + 23'($urandom % 32));
            end else if (rv_can_read()) begin
                set_rv(1'b0, 23'h706000 + 23'($urandom % 32));
            end
            if ($urandom % 2 == 0 && cpu_can_read()) begin
                set_cpu(1'b0, 22'h006000 + 22'($urandom % 32));
            end
            drive_cycle();
        end
        finish_test();
    endtask

    task automatic test_conflict();
        int idx;
        start_test("conflict_priority");
        for (int i = 0; i < 100; i++) begin
            idx = $urandom % 32;
            s_load_ongoing = (i >= 50);
            set_cpu(1'b1, 22'h006000 + 22'(idx));
            set_rv(1'b1, 23'h706000 + 23'(idx));
            drive_cycle();
            if (cpu_can_read()) begin
                set_cpu(1'b0, 22'h006000 + 22'(idx));
            end
            drive_cycle();
        end
        s_load_ongoing = 1'b0;
        finish_test();
    endtask

    task automatic test_outside();
        start_test("outside_window");
        repeat (200) begin
            if (cpu_can_read()) begin
                if ($urandom % 4 == 0) begin
                    set_cpu(1'b0, 22'h006000 + 22'($urandom % 32));
                end else if ($urandom % 2 == 0) begin
                    set_cpu(1'b0, 22'($urandom % 'h6000));
                end else begin
                    set_cpu(1'b0, 22'h008000 + 22'($urandom % 'h3000));
                end
            end
            if ($urandom % 4 == 0) begin
                set_rv(1'b1, 23'($urandom % 'h706000));
            end else if (rv_can_read()) begin
                // Below and above the RV window
                if ($urandom % 2 == 0) begin
                    set_rv(1'b0, 23'($urandom % 'h706000));
                end else begin
                    set_rv(1'b0, 23'h708000 + 23'($urandom % 'h8000));
                end
            end
            drive_cycle();
        end
        finish_test();
    endtask

    task automatic test_loader();
        int next;
        start_test("rom_loader");
        s_loading = 1'b1;
        repeat (100) begin
            s_ld_v = 1'b1;
            s_ld_req.we = 1'($urandom % 2);
            s_ld_req.addr = 22'h006000 + 22'($urandom % 32);
            s_ld_req.wdata = byte_t'($urandom);
            if ($urandom % 2 == 0) begin
                set_cpu(1'($urandom % 2), 22'h006000 + 22'($urandom % 32));
            end
            drive_cycle();
        end
        s_loading = 1'b0;
        next = 0;
        while (next < 32) begin
            if (cpu_can_read()) begin
                set_cpu(1'b0, 22'h006000 + 22'(next));
                next++;
            end
            drive_cycle();
        end
        finish_test();
    endtask

    initial begin
        void'($urandom(55));
        for (int i = 0; i < 256; i++) begin
            cpu_sdram[i] = byte_t'($urandom);
            rv_sdram[i] = rv_data_t'($urandom);
        end
        i_resetn = 1'b0;
        i_cpu_req_valid = 1'b0;
        i_cpu_req = '0;
        i_rom_loading = 1'b0;
        i_loader_req_valid = 1'b0;
        i_loader_req = '0;
        i_rv_req = 1'b0;
        i_rv_addr = '0;
        i_rv_word = 1'b0;
        i_rv_wdata = '0;
        i_rv_wstrb = '0;
        i_rv_ds = '0;
        i_wram_load_ongoing = 1'b0;
        i_cpu_ext_rvalid = 1'b0;
        i_cpu_ext_rdata = '0;
        i_rv_ext_rvalid = 1'b0;
        i_rv_ext_rdata = '0;
        s_resetn = 1'b0;
        s_cpu_v = 1'b0;
        s_cpu_req = '0;
        s_loading = 1'b0;
        s_ld_v = 1'b0;
        s_ld_req = '0;
        s_rv_v = 1'b0;
        s_rv_addr = '0;
        s_rv_word = 1'b0;
        s_rv_wdata = '0;
        s_rv_wstrb = '0;
        s_rv_ds = '0;
        s_load_ongoing = 1'b0;

        test_reset();
        test_cpu_rw();
        test_rv_map();
        test_conflict();
        test_outside();
        test_loader();

        $display("Tests run: %0d, errors: %0d", tests_run, total_errs);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+dv
verilog/wram_pkg.sv
verilog/cpu_port_decode.sv
verilog/rv_port_decode.sv
verilog/wram_arbiter_ctrl.sv
verilog/wram_bram.sv
verilog/wram_return_mux.sv
verilog/shared_wram_top.sv
dv/tb_shared_wram.sv

// File: verilog/cpu_port_decode.sv
/*
 * CPU-side request decoder. Picks the loader or the CPU as the source
 * and checks the address against the 0x6000 WRAM window.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_port_decode
    import wram_pkg::*;
(
    input  wire       i_rom_loading,
    input  wire       i_loader_req_valid,
    input  cpu_req_t  i_loader_req,
    input  wire       i_cpu_req_valid,
    input  cpu_req_t  i_cpu_req,
    output logic      o_valid,
    output cpu_req_t  o_req,
    output wram_hit_t o_hit
);

    cpu_addr_t offset;
    logic      in_window;

    // Loader owns the bus while a ROM is being loaded
    always_comb begin
        if (i_rom_loading) begin
            o_valid  = i_loader_req_valid;
            o_req    = i_loader_req;
            // Loader traffic is write-only
            o_req.we = 1'b1;
        end else begin
            o_valid = i_cpu_req_valid;
            o_req   = i_cpu_req;
        end
    end

    assign offset = o_req.addr - CPU_WRAM_BASE;

    // Half-open window [base, base + depth)
    assign in_window = (o_req.addr >= CPU_WRAM_BASE)
                    && (offset < cpu_addr_t'(WRAM_DEPTH));

    always_comb begin
        o_hit.hit   = o_valid && in_window;
        o_hit.we    = o_req.we;
        o_hit.index = offset[WRAM_INDEX_W-1:0];
    end

endmodule

`default_nettype wire

// File: verilog/rv_port_decode.sv
/*
 * RISC-V side request decoder. Selects the 16-bit write half from the
 * 32-bit bus and checks the byte address against the RV WRAM window.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_port_decode
    import wram_pkg::*;
(
    input  wire        i_rv_req,
    input  rv_addr_t   i_rv_addr,
    input  wire        i_rv_word,
    input  wire [31:0] i_rv_wdata,
    input  wire [3:0]  i_rv_wstrb,
    input  wire [1:0]  i_rv_ds,
    output logic       o_valid,
    output rv_req_t    o_req,
    output wram_hit_t  o_hit
);

    rv_addr_t offset;
    rv_data_t wr_half;
    logic     is_write;
    logic     in_window;

    // Any strobe bit set means a write
    assign is_write = |i_rv_wstrb;

    // Word select picks the upper or lower half of the bus
    assign wr_half = i_rv_word ? i_rv_wdata[31:16] : i_rv_wdata[15:0];

    assign offset = i_rv_addr - RV_WRAM_BASE;

    assign in_window = (i_rv_addr >= RV_WRAM_BASE)
                    && (offset < rv_addr_t'(WRAM_DEPTH));

    assign o_valid = i_rv_req;

    always_comb begin
        o_req.we    = is_write;
        o_req.addr  = i_rv_addr;
        o_req.wdata = wr_half;
        o_req.ds    = i_rv_ds;
    end

    always_comb begin
        o_hit.hit   = i_rv_req && in_window;
        o_hit.we    = is_write;
        o_hit.index = offset[WRAM_INDEX_W-1:0];
    end

endmodule

`default_nettype wire

// File: verilog/shared_wram_top.sv
/*
 * Shared work-RAM top level for the NES CPU and the RISC-V softcore.
 * Window hits are served by block RAM, all writes and other reads go to SDRAM.
 */
`timescale 1ns/1ps
`default_nettype none

module shared_wram_top
    import wram_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_resetn,

    // NES CPU and ROM loader
    input  wire        i_cpu_req_valid,
    input  cpu_req_t   i_cpu_req,
    input  wire        i_rom_loading,
    input  wire        i_loader_req_valid,
    input  cpu_req_t   i_loader_req,

    // RISC-V softcore
    input  wire        i_rv_req,
    input  rv_addr_t   i_rv_addr,
    input  wire        i_rv_word,
    input  wire [31:0] i_rv_wdata,
    input  wire [3:0]  i_rv_wstrb,
    input  wire [1:0]  i_rv_ds,

    input  wire        i_wram_load_ongoing,

    // SDRAM request side
    output logic       o_cpu_ext_valid,
    output cpu_req_t   o_cpu_ext_req,
    output logic       o_rv_ext_valid,
    output rv_req_t    o_rv_ext_req,
    input  wire        i_cpu_ext_rvalid,
    input  byte_t      i_cpu_ext_rdata,
    input  wire        i_rv_ext_rvalid,
    input  rv_data_t   i_rv_ext_rdata,

    // Read returns
    output logic       o_cpu_rvalid,
    output byte_t      o_cpu_rdata,
    output logic       o_rv_rvalid,
    output rv_data_t   o_rv_rdata
);

    logic        cpu_valid;
    cpu_req_t    cpu_req;
    wram_hit_t   cpu_hit;
    logic        rv_valid;
    rv_req_t     rv_req;
    wram_hit_t   rv_hit;
    logic        ram_we;
    logic        ram_re;
    wram_index_t ram_index;
    byte_t       ram_wdata;
    byte_t       ram_rdata;
    read_owner_e read_owner;

    cpu_port_decode cpu_dec_i (
        .i_rom_loading      (i_rom_loading),
        .i_loader_req_valid (i_loader_req_valid),
        .i_loader_req       (i_loader_req),
        .i_cpu_req_valid    (i_cpu_req_valid),
        .i_cpu_req          (i_cpu_req),
        .o_valid            (cpu_valid),
        .o_req              (cpu_req),
        .o_hit              (cpu_hit)
    );

    rv_port_decode rv_dec_i (
        .i_rv_req   (i_rv_req),
        .i_rv_addr  (i_rv_addr),
        .i_rv_word  (i_rv_word),
        .i_rv_wdata (i_rv_wdata),
        .i_rv_wstrb (i_rv_wstrb),
        .i_rv_ds    (i_rv_ds),
        .o_valid    (rv_valid),
        .o_req      (rv_req),
        .o_hit      (rv_hit)
    );

    wram_arbiter_ctrl arb_i (
        .i_clk               (i_clk),
        .i_resetn            (i_resetn),
        .i_wram_load_ongoing (i_wram_load_ongoing),
        .i_cpu_valid         (cpu_valid),
        .i_cpu_req           (cpu_req),
        .i_cpu_hit           (cpu_hit),
        .i_rv_valid          (rv_valid),
        .i_rv_req            (rv_req),
        .i_rv_hit            (rv_hit),
        .o_ram_we            (ram_we),
        .o_ram_re            (ram_re),
        .o_ram_index         (ram_index),
        .o_ram_wdata         (ram_wdata),
        .o_cpu_ext_valid     (o_cpu_ext_valid),
        .o_cpu_ext_req       (o_cpu_ext_req),
        .o_rv_ext_valid      (o_rv_ext_valid),
        .o_rv_ext_req        (o_rv_ext_req),
        .o_read_owner        (read_owner)
    );

    wram_bram bram_i (
        .i_clk   (i_clk),
        .i_we    (ram_we),
        .i_re    (ram_re),
        .i_index (ram_index),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

    wram_return_mux ret_i (
        .i_clk            (i_clk),
        .i_resetn         (i_resetn),
        .i_read_owner     (read_owner),
        .i_ram_rdata      (ram_rdata),
        .i_cpu_ext_rvalid (i_cpu_ext_rvalid),
        .i_cpu_ext_rdata  (i_cpu_ext_rdata),
        .i_rv_ext_rvalid  (i_rv_ext_rvalid),
        .i_rv_ext_rdata   (i_rv_ext_rdata),
        .o_cpu_rvalid     (o_cpu_rvalid),
        .o_cpu_rdata      (o_cpu_rdata),
        .o_rv_rvalid      (o_rv_rvalid),
        .o_rv_rdata       (o_rv_rdata)
    );

endmodule

`default_nettype wire

// File: verilog/wram_arbiter_ctrl.sv
/*
 * Per-cycle WRAM grant between CPU and RV, SDRAM forwarding of writes and
 * losing reads, and the owner tag of each granted RAM read.
 */
`timescale 1ns/1ps
`default_nettype none

module wram_arbiter_ctrl
    import wram_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_resetn,
    input  wire         i_wram_load_ongoing,
    input  wire         i_cpu_valid,
    input  cpu_req_t    i_cpu_req,
    input  wram_hit_t   i_cpu_hit,
    input  wire         i_rv_valid,
    input  rv_req_t     i_rv_req,
    input  wram_hit_t   i_rv_hit,
    output logic        o_ram_we,
    output logic        o_ram_re,
    output wram_index_t o_ram_index,
    output byte_t       o_ram_wdata,
    output logic        o_cpu_ext_valid,
    output cpu_req_t    o_cpu_ext_req,
    output logic        o_rv_ext_valid,
    output rv_req_t     o_rv_ext_req,
    output read_owner_e o_read_owner
);

    logic        grant_cpu;
    logic        grant_rv;
    read_owner_e next_owner;

    // RV only beats the CPU while a save-file load is running
    assign grant_rv  = i_rv_hit.hit && (!i_cpu_hit.hit || i_wram_load_ongoing);
    assign grant_cpu = i_cpu_hit.hit && !grant_rv;

    always_comb begin
        o_ram_we    = 1'b0;
        o_ram_re    = 1'b0;
        o_ram_index = i_cpu_hit.index;
        o_ram_wdata = i_cpu_req.wdata;
        if (grant_cpu) begin
            o_ram_we = i_cpu_hit.we;
            o_ram_re = !i_cpu_hit.we;
        end else if (grant_rv) begin
            o_ram_we    = i_rv_hit.we;
            o_ram_re    = !i_rv_hit.we;
            o_ram_index = i_rv_hit.index;
            // WRAM is byte-wide, keep the low byte of the half
            o_ram_wdata = i_rv_req.wdata[7:0];
        end
    end

    // Writes always reach SDRAM, reads only when the RAM was not granted
    assign o_cpu_ext_valid = i_cpu_valid && (i_cpu_req.we || !grant_cpu);
    assign o_cpu_ext_req   = i_cpu_req;
    assign o_rv_ext_valid  = i_rv_valid && (i_rv_req.we || !grant_rv);
    assign o_rv_ext_req    = i_rv_req;

    always_comb begin
        if (grant_cpu && !i_cpu_hit.we) begin
            next_owner = CPU;
        end else if (grant_rv && !i_rv_hit.we) begin
            next_owner = RV;
        end else begin
            next_owner = NONE;
        end
    end

    // Tag lines up with the registered RAM read data
    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            o_read_owner <= NONE;
        end else begin
            o_read_owner <= next_owner;
        end
    end

endmodule

`default_nettype wire

// File: verilog/wram_bram.sv
/*
 * 8 KB byte-wide work RAM, one access port with registered read data.
 * Maps onto a single block RAM; contents are not initialised.
 */
`timescale 1ns/1ps
`default_nettype none

module wram_bram
    import wram_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_we,
    input  wire         i_re,
    input  wram_index_t i_index,
    input  byte_t       i_wdata,
    output byte_t       o_rdata
);

    byte_t mem [WRAM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_index] <= i_wdata;
        end
    end

    // Read-before-write on a shared cycle
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            o_rdata <= mem[i_index];
        end
    end

endmodule

`default_nettype wire

// File: verilog/wram_pkg.sv
/*
 * Shared types and constants for the NES / RISC-V work-RAM arbiter.
 * Imported by every module of the shared WRAM design.
 */
`default_nettype none

package wram_pkg;

    // Window geometry, fixed by the NES memory map
    localparam int WRAM_DEPTH   = 8192;
    localparam int WRAM_INDEX_W = 13;
    localparam int CPU_ADDR_W   = 22;
    localparam int RV_ADDR_W    = 23;

    typedef logic [WRAM_INDEX_W-1:0] wram_index_t;
    typedef logic [CPU_ADDR_W-1:0]   cpu_addr_t;
    typedef logic [RV_ADDR_W-1:0]    rv_addr_t;
    typedef logic [7:0]              byte_t;
    typedef logic [15:0]             rv_data_t;

    // Address of RAM index 0 as seen by each master
    localparam cpu_addr_t CPU_WRAM_BASE = 22'h00_6000;
    localparam rv_addr_t  RV_WRAM_BASE  = 23'h70_6000;

    // CPU or loader request
    typedef struct packed {
        logic      we;
        cpu_addr_t addr;
        byte_t     wdata;
    } cpu_req_t;

    // RV request, write half already selected
    typedef struct packed {
        logic     we;
        rv_addr_t addr;
        rv_data_t wdata;
        logic [1:0] ds;
    } rv_req_t;

    // Decoder verdict against the WRAM window
    typedef struct packed {
        logic        hit;
        logic        we;
        wram_index_t index;
    } wram_hit_t;

    typedef enum logic [1:0] {NONE = 2'd0, CPU = 2'd1, RV = 2'd2} read_owner_e;

endpackage

`default_nettype wire

// File: verilog/wram_return_mux.sv
/*
 * Read return path. Routes RAM data by owner tag, otherwise passes the
 * SDRAM replies through, all behind one output register stage.
 */
`timescale 1ns/1ps
`default_nettype none

module wram_return_mux
    import wram_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_resetn,
    input  read_owner_e i_read_owner,
    input  byte_t       i_ram_rdata,
    input  wire         i_cpu_ext_rvalid,
    input  byte_t       i_cpu_ext_rdata,
    input  wire         i_rv_ext_rvalid,
    input  rv_data_t    i_rv_ext_rdata,
    output logic        o_cpu_rvalid,
    output byte_t       o_cpu_rdata,
    output logic        o_rv_rvalid,
    output rv_data_t    o_rv_rdata
);

    logic ram_to_cpu;
    logic ram_to_rv;

    assign ram_to_cpu = (i_read_owner == CPU);
    assign ram_to_rv  = (i_read_owner == RV);

    // RAM return takes precedence if both land together
    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            o_cpu_rvalid <= 1'b0;
            o_cpu_rdata  <= '0;
        end else begin
            o_cpu_rvalid <= ram_to_cpu || i_cpu_ext_rvalid;
            o_cpu_rdata  <= ram_to_cpu ? i_ram_rdata : i_cpu_ext_rdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            o_rv_rvalid <= 1'b0;
            o_rv_rdata  <= '0;
        end else begin
            o_rv_rvalid <= ram_to_rv || i_rv_ext_rvalid;
            // WRAM byte comes back zero-extended
            o_rv_rdata  <= ram_to_rv ? {8'h00, i_ram_rdata} : i_rv_ext_rdata;
        end
    end

endmodule

`default_nettype wire
